// ==== source/bus_int_consts.svh ====
// ------------------------------
// Bus interconnect constants
// Widths, reset values and fixed readback words
// ------------------------------

`ifndef BUS_INT_CONSTS_SVH
`define BUS_INT_CONSTS_SVH

// ------------------------------
// Bus widths
// ------------------------------

// Settings and readback data
`define BUS_INT_DATA_W 32

// Settings and readback address
`define BUS_INT_ADDR_W 8

// Ethernet PHY status word per port
`define BUS_INT_PHY_W 16

// ------------------------------
// Reset values and fixed words
// ------------------------------

// Bit 6 set selects the GPSDO reference
`define BUS_INT_CLK_CTRL_RESET 8'h40

// Major number in the upper half, minor in the lower
`define BUS_INT_COMPAT {16'd1000, 16'd0}

// Compute engines reported on readback
`define BUS_INT_NUM_CE 32'd3

`endif

// ==== source/bus_int_pkg.sv ====
// ------------------------------
// Bus interconnect types
// Address maps and the structs shared by the control blocks
// ------------------------------

`include "bus_int_consts.svh"

package bus_int_pkg;

   // Settings bus register map
   typedef enum logic [`BUS_INT_ADDR_W-1:0] {
      SR_LEDS       = 8'd0,
      SR_SW_RST     = 8'd1,
      SR_CLOCK_CTRL = 8'd2,
      SR_SFPP_CTRL0 = 8'd8,
      SR_SFPP_CTRL1 = 8'd9
   } sr_addr_e;

   // Readback bus address map
   typedef enum logic [`BUS_INT_ADDR_W-1:0] {
      RB_COUNTER      = 8'd0,
      RB_CLK_STATUS   = 8'd3,
      RB_COMPAT_NUM   = 8'd6,
      RB_NUM_CE       = 8'd7,
      RB_SFPP_STATUS0 = 8'd8,
      RB_SFPP_STATUS1 = 8'd9
   } rb_addr_e;

   typedef struct packed {
      logic                       stb;
      logic [`BUS_INT_ADDR_W-1:0] addr;
      logic [`BUS_INT_DATA_W-1:0] data;
   } set_bus_t;

   // SFP+ module pins, in readback bit order
   typedef struct packed {
      logic mod_abs;
      logic tx_fault;
      logic rx_los;
   } sfp_pins_t;

   typedef struct packed {
      logic [`BUS_INT_PHY_W-1:0] phy;
      sfp_pins_t                 chgd;
      sfp_pins_t                 sync;
   } sfp_status_t;

   typedef struct packed {
      logic [7:0] leds;
      logic [3:0] sw_rst;
      logic [7:0] clock_control;
      logic [1:0] sfp0_rs;
      logic [1:0] sfp1_rs;
   } ctrl_regs_t;

endpackage

// ==== source/setting_regs.sv ====
// ------------------------------
// Settings register decode
// Loads the control registers from settings bus writes
// ------------------------------

`timescale 1ns/10ps

`include "bus_int_consts.svh"

module setting_regs (
   input  logic                    clk,
   input  logic                    i_rst,
   input  bus_int_pkg::set_bus_t   i_set,
   output bus_int_pkg::ctrl_regs_t o_ctrl
);

   bus_int_pkg::sr_addr_e set_addr;

   assign set_addr = bus_int_pkg::sr_addr_e'(i_set.addr);

   // ------------------------------
   // Register file
   // ------------------------------

   // sw_rst bits
   // [0] PHY reset
   // [1] radio clock domain reset
   // [2] radio clock PLL reset
   // [3] ADC IDELAYCTRL reset
   //
   // sfpN_rs bits mean "drive the rate-select pin low"
   always_ff @(posedge clk) begin
      if (i_rst) begin
         o_ctrl.leds          <= '0;
         o_ctrl.sw_rst        <= '0;
         o_ctrl.clock_control <= `BUS_INT_CLK_CTRL_RESET;
         o_ctrl.sfp0_rs       <= '0;
         o_ctrl.sfp1_rs       <= '0;
      end else if (i_set.stb) begin
         case (set_addr)
            bus_int_pkg::SR_LEDS: begin
               o_ctrl.leds <= i_set.data[7:0];
            end
            bus_int_pkg::SR_SW_RST: begin
               o_ctrl.sw_rst <= i_set.data[3:0];
            end
            bus_int_pkg::SR_CLOCK_CTRL: begin
               o_ctrl.clock_control <= i_set.data[7:0];
            end
            bus_int_pkg::SR_SFPP_CTRL0: begin
               o_ctrl.sfp0_rs <= i_set.data[1:0];
            end
            bus_int_pkg::SR_SFPP_CTRL1: begin
               o_ctrl.sfp1_rs <= i_set.data[1:0];
            end
            default: begin
               // Unmapped address, nothing to load
            end
         endcase
      end
   end

   // ------------------------------
   // Checks
   // ------------------------------

   // Soft resets move only on a write to their own address, or on reset
   a_sw_rst_write: assert property (@(posedge clk) disable iff (i_rst)
      $changed(o_ctrl.sw_rst) |->
         $past(i_rst) ||
         $past(i_set.stb && (i_set.addr == bus_int_pkg::SR_SW_RST)));

endmodule

// ==== source/sfp_status_mon.sv ====
// ------------------------------
// SFP+ status monitor
// Synchronizes module pins and PHY status, keeps sticky change flags
// ------------------------------

`timescale 1ns/10ps

`include "bus_int_consts.svh"

module sfp_status_mon (
   input  logic                          clk,
   input  logic                          i_rst,
   input  bus_int_pkg::sfp_pins_t        i_sfp0,
   input  bus_int_pkg::sfp_pins_t        i_sfp1,
   input  logic [`BUS_INT_PHY_W-1:0]     i_phy0,
   input  logic [`BUS_INT_PHY_W-1:0]     i_phy1,
   input  logic                          i_clr0,
   input  logic                          i_clr1,
   output bus_int_pkg::sfp_status_t      o_status0,
   output bus_int_pkg::sfp_status_t      o_status1
);

   // Index 0 and 1 follow the SFP+ port number
   bus_int_pkg::sfp_pins_t      pin_in   [2];
   bus_int_pkg::sfp_pins_t      pin_s1   [2];
   bus_int_pkg::sfp_pins_t      pin_s2   [2];
   bus_int_pkg::sfp_pins_t      pin_prev [2];
   bus_int_pkg::sfp_pins_t      chgd_q   [2];
   logic [`BUS_INT_PHY_W-1:0]   phy_in   [2];
   logic [`BUS_INT_PHY_W-1:0]   phy_s1   [2];
   logic [`BUS_INT_PHY_W-1:0]   phy_s2   [2];
   logic                        clr      [2];

   assign pin_in[0] = i_sfp0;
   assign pin_in[1] = i_sfp1;
   assign phy_in[0] = i_phy0;
   assign phy_in[1] = i_phy1;
   assign clr[0]    = i_clr0;
   assign clr[1]    = i_clr1;

   // ------------------------------
   // Synchronizers and edge detect
   // ------------------------------

   // Every pin and PHY bit is treated as asynchronous
   always_ff @(posedge clk) begin
      for (int p = 0; p < 2; p++) begin
         pin_s1[p]   <= pin_in[p];
         pin_s2[p]   <= pin_s1[p];
         pin_prev[p] <= pin_s2[p];
         phy_s1[p]   <= phy_in[p];
         phy_s2[p]   <= phy_s1[p];
      end
   end

   // Sticky flags, a read clear beats a new change
   always_ff @(posedge clk) begin
      for (int p = 0; p < 2; p++) begin
         if (i_rst || clr[p]) begin
            chgd_q[p] <= '0;
         end else begin
            chgd_q[p] <= chgd_q[p] | (pin_s2[p] ^ pin_prev[p]);
         end
      end
   end

   assign o_status0 = '{phy: phy_s2[0], chgd: chgd_q[0], sync: pin_s2[0]};
   assign o_status1 = '{phy: phy_s2[1], chgd: chgd_q[1], sync: pin_s2[1]};

   // ------------------------------
   // Checks
   // ------------------------------

   // A flag rises only after the synchronized bit moved between two edges
   for (genvar p = 0; p < 2; p++) begin : g_port_chk
      for (genvar b = 0; b < 3; b++) begin : g_bit_chk
         a_flag_cause: assert property (@(posedge clk) disable iff (i_rst)
            $rose(chgd_q[p][b]) |-> ($past(pin_s2[p][b], 1) != $past(pin_s2[p][b], 2)));
      end
   end

endmodule

// ==== source/readback_mux.sv ====
// ------------------------------
// Readback select
// Cycle counter and the readback word for each address
// ------------------------------

`timescale 1ns/10ps

`include "bus_int_consts.svh"

module readback_mux (
   input  logic                         clk,
   input  logic                         i_rst,
   input  logic [`BUS_INT_ADDR_W-1:0]   i_rb_addr,
   input  logic [7:0]                   i_clock_status,
   input  bus_int_pkg::sfp_status_t     i_status0,
   input  bus_int_pkg::sfp_status_t     i_status1,
   output logic [`BUS_INT_DATA_W-1:0]   o_rb_data
);

   logic [`BUS_INT_DATA_W-1:0] counter_q;
   bus_int_pkg::rb_addr_e      rb_sel;

   // PHY status on top, pins and flags at the bottom
   function automatic logic [`BUS_INT_DATA_W-1:0] status_word(
      input bus_int_pkg::sfp_status_t s
   );
      return {s.phy, 10'd0, s.chgd, s.sync};
   endfunction

   // Free-running, wraps silently
   always_ff @(posedge clk) begin
      if (i_rst) begin
         counter_q <= '0;
      end else begin
         counter_q <= counter_q + 1'b1;
      end
   end

   assign rb_sel = bus_int_pkg::rb_addr_e'(i_rb_addr);

   always_comb begin
      case (rb_sel)
         bus_int_pkg::RB_COUNTER:      o_rb_data = counter_q;
         bus_int_pkg::RB_CLK_STATUS:   o_rb_data = {24'd0, i_clock_status};
         bus_int_pkg::RB_COMPAT_NUM:   o_rb_data = `BUS_INT_COMPAT;
         bus_int_pkg::RB_NUM_CE:       o_rb_data = `BUS_INT_NUM_CE;
         bus_int_pkg::RB_SFPP_STATUS0: o_rb_data = status_word(i_status0);
         bus_int_pkg::RB_SFPP_STATUS1: o_rb_data = status_word(i_status1);
         default:                      o_rb_data = '0;
      endcase
   end

endmodule

// ==== source/bus_int_ctrl.sv ====
// ------------------------------
// Bus interconnect control and status
// Settings registers, SFP+ status and the readback bus
// ------------------------------

`timescale 1ns/10ps

`include "bus_int_consts.svh"

module bus_int_ctrl (
   input  logic                          clk,
   input  logic                          i_rst,
   // Settings bus
   input  bus_int_pkg::set_bus_t         i_set,
   // Readback bus
   input  logic [`BUS_INT_ADDR_W-1:0]    i_rb_addr,
   input  logic                          i_rb_rd_stb,
   // Board status
   input  logic [7:0]                    i_clock_status,
   input  bus_int_pkg::sfp_pins_t        i_sfp0,
   input  bus_int_pkg::sfp_pins_t        i_sfp1,
   input  logic [`BUS_INT_PHY_W-1:0]     i_phy0,
   input  logic [`BUS_INT_PHY_W-1:0]     i_phy1,
   output logic [`BUS_INT_DATA_W-1:0]    o_rb_data,
   output bus_int_pkg::ctrl_regs_t       o_ctrl
);

   bus_int_pkg::rb_addr_e    rb_sel;
   bus_int_pkg::sfp_status_t status0;
   bus_int_pkg::sfp_status_t status1;
   logic                     clr0;
   logic                     clr1;

   // ------------------------------
   // Read-clear pulses
   // ------------------------------

   // A strobed read of a status word consumes its change flags
   assign rb_sel = bus_int_pkg::rb_addr_e'(i_rb_addr);
   assign clr0   = i_rb_rd_stb && (rb_sel == bus_int_pkg::RB_SFPP_STATUS0);
   assign clr1   = i_rb_rd_stb && (rb_sel == bus_int_pkg::RB_SFPP_STATUS1);

   // ------------------------------
   // Blocks
   // ------------------------------

   setting_regs setting_regs_i (
      .clk    (clk),
      .i_rst  (i_rst),
      .i_set  (i_set),
      .o_ctrl (o_ctrl)
   );

   sfp_status_mon sfp_status_mon_i (
      .clk       (clk),
      .i_rst     (i_rst),
      .i_sfp0    (i_sfp0),
      .i_sfp1    (i_sfp1),
      .i_phy0    (i_phy0),
      .i_phy1    (i_phy1),
      .i_clr0    (clr0),
      .i_clr1    (clr1),
      .o_status0 (status0),
      .o_status1 (status1)
   );

   readback_mux readback_mux_i (
      .clk            (clk),
      .i_rst          (i_rst),
      .i_rb_addr      (i_rb_addr),
      .i_clock_status (i_clock_status),
      .i_status0      (status0),
      .i_status1      (status1),
      .o_rb_data      (o_rb_data)
   );

endmodule

// ==== bench/bus_int_ctrl_tb.sv ====
// ------------------------------
// Bus interconnect testbench
// Replays the stimulus file against o_ctrl and the readback bus
// ------------------------------

`timescale 1ns/10ps

`include "bus_int_consts.svh"

module bus_int_ctrl_tb;

   localparam int STIM_WORDS = 256;
   localparam int POLL_LIMIT = 50;

   logic                         clk;
   logic                         i_rst;
   bus_int_pkg::set_bus_t        i_set;
   logic [`BUS_INT_ADDR_W-1:0]   i_rb_addr;
   logic                         i_rb_rd_stb;
   logic [7:0]                   i_clock_status;
   bus_int_pkg::sfp_pins_t       i_sfp0;
   bus_int_pkg::sfp_pins_t       i_sfp1;
   logic [`BUS_INT_PHY_W-1:0]    i_phy0;
   logic [`BUS_INT_PHY_W-1:0]    i_phy1;
   logic [`BUS_INT_DATA_W-1:0]   o_rb_data;
   bus_int_pkg::ctrl_regs_t      o_ctrl;

   // Four words per stimulus record
   logic [31:0] stim [STIM_WORDS];
   logic [16:0] lfsr_q;
   int          checks;
   int          errors;
   int          test_errors;
   int          tests_run;
   int          tests_failed;

   bus_int_ctrl bus_int_ctrl_i (
      .clk            (clk),
      .i_rst          (i_rst),
      .i_set          (i_set),
      .i_rb_addr      (i_rb_addr),
      .i_rb_rd_stb    (i_rb_rd_stb),
      .i_clock_status (i_clock_status),
      .i_sfp0         (i_sfp0),
      .i_sfp1         (i_sfp1),
      .i_phy0         (i_phy0),
      .i_phy1         (i_phy1),
      .o_rb_data      (o_rb_data),
      .o_ctrl         (o_ctrl)
   );

   always #20 clk = ~clk;

   // ------------------------------
   // Random delays
   // ------------------------------

   // 17-bit Fibonacci LFSR, taps 17 and 14
   function automatic logic [16:0] lfsr_next(input logic [16:0] s);
      return {s[15:0], s[16] ^ s[13]};
   endfunction

   task automatic take_random(input int nbits, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < nbits; i++) begin
         lfsr_q = lfsr_next(lfsr_q);
         v = {v[30:0], lfsr_q[0]};
      end
   endtask

   // ------------------------------
   // Compare tasks
   // ------------------------------

   task automatic check_ctrl(input bus_int_pkg::ctrl_regs_t got,
                             input bus_int_pkg::ctrl_regs_t exp);
      checks++;
      if (got !== exp) begin
         $display("** Error: o_ctrl = 0x%06h, expected 0x%06h", got, exp);
         test_errors++;
      end
   endtask

   task automatic check_rb(input logic [`BUS_INT_DATA_W-1:0] got,
                           input logic [`BUS_INT_DATA_W-1:0] exp,
                           input logic [`BUS_INT_ADDR_W-1:0] addr);
      checks++;
      if (got !== exp) begin
         $display("** Error: o_rb_data at 0x%02h = 0x%08h, expected 0x%08h", addr, got, exp);
         test_errors++;
      end
   endtask

   // ------------------------------
   // Bus actions
   // ------------------------------

   // New value is visible one edge after the strobe
   task automatic drive_write(input logic [7:0] addr, input logic [31:0] data);
      @(posedge clk);
      i_set <= '{stb: 1'b1, addr: addr, data: data};
      @(posedge clk);
      i_set <= '{stb: 1'b0, addr: '0, data: '0};
      @(negedge clk);
   endtask

   task automatic read_word(input logic [7:0] addr, input logic stb, output logic [31:0] v);
      @(posedge clk);
      i_rb_addr   <= addr;
      i_rb_rd_stb <= stb;
      @(negedge clk);
      v = o_rb_data;
      @(posedge clk);
      i_rb_rd_stb <= 1'b0;
   endtask

   // Synchronized values show up a few edges late
   task automatic poll_word(input logic [7:0] addr, input logic [31:0] exp);
      int n;
      n = 0;
      @(posedge clk);
      i_rb_addr   <= addr;
      i_rb_rd_stb <= 1'b0;
      @(negedge clk);
      while (o_rb_data !== exp && n < POLL_LIMIT) begin
         @(negedge clk);
         n++;
      end
      checks++;
      if (o_rb_data !== exp) begin
         $display("Timed out waiting for address 0x%02h to read 0x%08h", addr, exp);
         test_errors++;
      end
   endtask

   task automatic counter_gap();
      logic [31:0] k;
      logic [31:0] first;
      @(posedge clk);
      i_rb_addr <= bus_int_pkg::RB_COUNTER;
      @(negedge clk);
      first = o_rb_data;
      take_random(4, k);
      k = k + 1;
      repeat (k) @(negedge clk);
      check_rb(o_rb_data, first + k, bus_int_pkg::RB_COUNTER);
   endtask

   task automatic close_test(input logic [31:0] num);
      tests_run++;
      if (test_errors == 0) begin
         $display("Test %0d passed", num);
      end else begin
         $display("Test %0d failed with %0d errors", num, test_errors);
         tests_failed++;
      end
      errors += test_errors;
      test_errors = 0;
   endtask

   // ------------------------------
   // Main sequence
   // ------------------------------

   initial begin
      logic [31:0] op;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] c;
      logic [31:0] v;
      int          idx;
      clk = 1'b0;
      i_rst = 1'b1;
      i_set = '0;
      i_rb_addr = '0;
      i_rb_rd_stb = 1'b0;
      i_clock_status = '0;
      i_sfp0 = '0;
      i_sfp1 = '0;
      i_phy0 = '0;
      i_phy1 = '0;
      lfsr_q = 17'd92512;
      checks = 0;
      errors = 0;
      test_errors = 0;
      tests_run = 0;
      tests_failed = 0;
      for (int i = 0; i < STIM_WORDS; i++) begin
         stim[i] = '0;
      end
      $readmemh("bench/bus_int_stimulus.txt", stim);
      repeat (10) @(posedge clk);
      i_rst <= 1'b0;
      idx = 0;
      while (idx + 3 < STIM_WORDS && stim[idx] != 0) begin
         op = stim[idx];
         a = stim[idx + 1];
         b = stim[idx + 2];
         c = stim[idx + 3];
         idx += 4;
         case (op)
            32'h1: begin
               drive_write(a[7:0], b);
               check_ctrl(o_ctrl, bus_int_pkg::ctrl_regs_t'(c[23:0]));
            end
            32'h2: begin
               @(posedge clk);
               if (a[0]) i_sfp1 <= bus_int_pkg::sfp_pins_t'(b[2:0]);
               else i_sfp0 <= bus_int_pkg::sfp_pins_t'(b[2:0]);
            end
            32'h3: begin
               @(posedge clk);
               if (a[0]) i_phy1 <= b[15:0];
               else i_phy0 <= b[15:0];
            end
            32'h4: begin
               @(posedge clk);
               i_clock_status <= b[7:0];
            end
            32'h5: begin
               if (c[1]) begin
                  poll_word(a[7:0], b);
               end else begin
                  read_word(a[7:0], c[0], v);
                  check_rb(v, b, a[7:0]);
               end
            end
            32'h6: counter_gap();
            32'h7: begin
               @(negedge clk);
               check_ctrl(o_ctrl, bus_int_pkg::ctrl_regs_t'(b[23:0]));
            end
            32'hF: close_test(a);
            default: begin
               $display("Unknown stimulus command 0x%0h in record %0d", op, idx / 4 - 1);
               test_errors++;
            end
         endcase
      end
      errors += test_errors;
      if (tests_run == 0) begin
         $display("No tests were read from the stimulus file");
      end
      $display("Tests: %0d, failed: %0d, checks: %0d, errors: %0d",
               tests_run, tests_failed, checks, errors);
      if (errors == 0 && tests_run > 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

// ==== bench/bus_int_stimulus.txt ====
// Columns: command, arg, value, extra (hex). 1 write addr data exp_ctrl, 2 pins port value,
// 3 PHY port value, 4 clock status, 5 read addr exp flags(1 strobe, 2 poll), 6 counter,
// 7 ctrl check exp, F end of test number, 0 end of file
7 0 00000400 0
5 06 03E80000 0
5 07 00000003 0
5 20 00000000 0
F 1 0 0
1 00 123456A5 00A50400
1 01 000000FF 00A5F400
1 02 000001C3 00A5FC30
1 08 00000007 00A5FC3C
1 09 00000006 00A5FC3E
1 05 FFFFFFFF 00A5FC3E
F 2 0 0
6 0 0 0
6 0 0 0
F 3 0 0
2 0 4 0
5 08 00000024 2
5 08 00000024 1
5 08 00000004 0
5 09 00000000 0
2 1 3 0
5 09 0000001B 2
5 09 0000001B 1
5 09 00000003 0
F 4 0 0
4 0 5A 0
5 03 0000005A 0
3 0 BEEF 0
5 08 BEEF0004 2
3 1 1234 0
5 09 12340003 2
F 5 0 0
0 0 0 0

// ==== build.f ====
+incdir+source
source/bus_int_pkg.sv
source/setting_regs.sv
source/sfp_status_mon.sv
source/readback_mux.sv
source/bus_int_ctrl.sv
bench/bus_int_ctrl_tb.sv

// ==== Makefile ====
TOP = bus_int_ctrl_tb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TESTS PASSED"

obj_dir/V$(TOP): build.f $(wildcard source/*) $(wildcard bench/*)
	verilator --binary --timing --assert -f build.f --top-module $(TOP)

lint:
	verilator --lint-only --timing --assert -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir
